// ==== src/cpu_config.svh ====
/* width, depth and phase-boundary macros for the accumulator core */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// bus widths, one word each
`define CPU_ADDR_W 8
`define CPU_DATA_W 8

// ram words, full 8-bit address space
`define CPU_MEM_DEPTH 256

// operand field of an instruction byte
`define CPU_OPND_W 5

// steps per instruction and where each phase starts
`define CPU_SEQ_LEN 10
`define CPU_FETCH_FIRST 1   // seq0 is the dead step
`define CPU_DECODE_FIRST 4
`define CPU_EXEC_FIRST 8

`endif

// ==== src/isaPkg.sv ====
/* instruction set types
   opcode enum and sequencer phase enum */
package isaPkg;

    // top 3 bits of every instruction byte
    typedef enum logic [2:0] {
        LDA = 3'd0, // acc = mem[opnd]
        STA = 3'd1, // mem[opnd] = acc
        ADD = 3'd2, // 8-bit wrap
        SUB = 3'd3, // 8-bit wrap
        JMP = 3'd4,
        JZ  = 3'd5, // taken when acc is zero
        OUT = 3'd6, // acc to outData
        HLT = 3'd7  // freeze until reset
    } opcodeT;

    // coarse view of the one-hot ring
    typedef enum logic [1:0] {
        phDead   = 2'd0,
        phFetch  = 2'd1,
        phDecode = 2'd2,
        phExec   = 2'd3
    } phaseT;

endpackage : isaPkg

// ==== src/busPkg.sv ====
/* shared memory types, bus owner enum */
package busPkg;

    // who drives the single ram port this cycle
    typedef enum logic [1:0] {
        ownNone  = 2'd0,
        ownHost  = 2'd1,
        ownExec  = 2'd2,
        ownFetch = 2'd3
    } ownerT;

endpackage : busPkg

// ==== src/phaser.sv ====
/* phaser, ten-step one-hot phase sequencer
   holds on stall or halt, decodes the coarse phase */
`include "cpu_config.svh"

module phaser (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     run,
    input  logic                     stall,  // memory not granted
    input  logic                     halt,
    output logic [`CPU_SEQ_LEN-1:0]  seq,
    output isaPkg::phaseT            phase
);

    logic       advance;
    logic [3:0] stepIdx;

    assign advance = run && !stall && !halt;

    // ring of ten, starts on the dead step
    always_ff @(posedge clk) begin
        if (!rstN) begin
            seq <= `CPU_SEQ_LEN'(1);
        end else if (advance) begin
            seq <= {seq[`CPU_SEQ_LEN-2:0], seq[`CPU_SEQ_LEN-1]}; // rotate left
        end
    end

    // one-hot to step number
    always_comb begin
        stepIdx = '0;
        for (int i = 0; i < `CPU_SEQ_LEN; i++) begin
            if (seq[i]) stepIdx = 4'(i);
        end
    end

    always_comb begin
        if (stepIdx < 4'(`CPU_FETCH_FIRST)) begin
            phase = isaPkg::phDead;     // first clock does nothing
        end else if (stepIdx < 4'(`CPU_DECODE_FIRST)) begin
            phase = isaPkg::phFetch;
        end else if (stepIdx < 4'(`CPU_EXEC_FIRST)) begin
            phase = isaPkg::phDecode;
        end else begin
            phase = isaPkg::phExec;
        end
    end

    // ring never loses or gains a token
    seqOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot(seq));

    // a stalled memory access freezes the whole instruction
    stallHolds: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable(seq));

endmodule : phaser

// ==== src/fetchUnit.sv ====
/* fetchUnit, program counter and instruction register
   reads one byte per instruction during fetch */
`include "cpu_config.svh"

module fetchUnit (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`CPU_SEQ_LEN-1:0]  seq,
    input  logic                     branchTaken,
    input  logic [`CPU_ADDR_W-1:0]   branchTarget,
    output logic                     memReq,
    output logic [`CPU_ADDR_W-1:0]   memAddr,
    input  logic [`CPU_DATA_W-1:0]   memRdData,
    input  logic                     memRdValid,
    output logic [`CPU_DATA_W-1:0]   instr,
    output logic [`CPU_ADDR_W-1:0]   pc
);

    // request at seq1
    // the ring sits on seq1 until the arbiter grants, so the request holds
    assign memReq  = seq[`CPU_FETCH_FIRST];
    assign memAddr = pc;

    // program counter
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (memRdValid) begin
            pc <= pc + 1'b1;                // step past the byte just read
        end else if (seq[`CPU_SEQ_LEN-1] && branchTaken) begin
            pc <= branchTarget;             // commit on the seq9 edge
        end
    end

    // instruction byte arrives the cycle after the grant
    always_ff @(posedge clk) begin
        if (memRdValid) begin
            instr <= memRdData;
        end
    end

endmodule : fetchUnit

// ==== src/execUnit.sv ====
/* execUnit, decode, accumulator and data memory access
   branches, output strobe and halt flag */
`include "cpu_config.svh"

module execUnit (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`CPU_SEQ_LEN-1:0]  seq,
    input  logic [`CPU_DATA_W-1:0]   instr,
    output logic                     memReq,
    output logic                     memWe,
    output logic [`CPU_ADDR_W-1:0]   memAddr,
    output logic [`CPU_DATA_W-1:0]   memWrData,
    input  logic [`CPU_DATA_W-1:0]   memRdData,
    input  logic                     memRdValid,
    output logic                     branchTaken,
    output logic [`CPU_ADDR_W-1:0]   branchTarget,
    output logic                     outValid,
    output logic [`CPU_DATA_W-1:0]   outData,
    output logic                     halted
);

    localparam int ExecLast = `CPU_SEQ_LEN - 1;

    isaPkg::opcodeT              opReg;
    logic [`CPU_OPND_W-1:0]      operand;
    logic                        needRd;    // LDA ADD SUB
    logic                        needWr;    // STA
    logic [`CPU_DATA_W-1:0]      acc;
    logic [`CPU_ADDR_W-1:0]      opndAddr;

    // first decode step splits the byte
    always_ff @(posedge clk) begin
        if (!rstN) begin
            opReg <= isaPkg::LDA;
        end else if (seq[`CPU_DECODE_FIRST]) begin
            opReg <= isaPkg::opcodeT'(instr[`CPU_DATA_W-1:`CPU_OPND_W]);
        end
    end

    always_ff @(posedge clk) begin
        if (seq[`CPU_DECODE_FIRST]) begin
            operand <= instr[`CPU_OPND_W-1:0];  // payload, no reset
        end
    end

    // second decode step works out the memory need
    always_ff @(posedge clk) begin
        if (!rstN) begin
            needRd <= 1'b0;
            needWr <= 1'b0;
        end else if (seq[`CPU_DECODE_FIRST+1]) begin
            needRd <= opReg inside {isaPkg::LDA, isaPkg::ADD, isaPkg::SUB};
            needWr <= opReg == isaPkg::STA;
        end
    end

    // operand reaches only the low 32 bytes
    assign opndAddr = {{(`CPU_ADDR_W-`CPU_OPND_W){1'b0}}, operand};

    assign memReq    = seq[`CPU_EXEC_FIRST] && (needRd || needWr);
    assign memWe     = seq[`CPU_EXEC_FIRST] && needWr;
    assign memAddr   = opndAddr;
    assign memWrData = acc;

    // jumps commit in fetchUnit on the same edge
    assign branchTaken  = seq[ExecLast] &&
                          (opReg == isaPkg::JMP || (opReg == isaPkg::JZ && acc == '0));
    assign branchTarget = opndAddr;

    assign outValid = seq[ExecLast] && opReg == isaPkg::OUT;
    assign outData  = acc;

    // rdValid lasts one cycle so a held seq9 adds only once
    always_ff @(posedge clk) begin
        if (!rstN) begin
            acc <= '0;
        end else if (seq[ExecLast] && memRdValid) begin
            case (opReg)
                isaPkg::LDA: acc <= memRdData;
                isaPkg::ADD: acc <= acc + memRdData; // wraps at 256
                isaPkg::SUB: acc <= acc - memRdData;
                default:     acc <= acc;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            halted <= 1'b0;
        end else if (seq[ExecLast] && opReg == isaPkg::HLT) begin
            halted <= 1'b1;                  // sticky until reset
        end
    end

    // only a store writes memory
    weOnlyStore: assert property (@(posedge clk) disable iff (!rstN)
        memWe |-> opReg == isaPkg::STA);

endmodule : execUnit

// ==== src/sharedMem.sv ====
/* sharedMem, fixed-priority arbiter host > exec > fetch
   single-port synchronous ram with registered, steered read data */
`include "cpu_config.svh"

module sharedMem (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    run,         // host locked out while high
    input  logic                    hostReq,
    input  logic [`CPU_ADDR_W-1:0]  hostAddr,
    input  logic [`CPU_DATA_W-1:0]  hostData,
    output logic                    hostGnt,
    input  logic                    fetchReq,
    input  logic [`CPU_ADDR_W-1:0]  fetchAddr,
    output logic [`CPU_DATA_W-1:0]  fetchRdData,
    output logic                    fetchRdValid,
    input  logic                    execReq,
    input  logic                    execWe,
    input  logic [`CPU_ADDR_W-1:0]  execAddr,
    input  logic [`CPU_DATA_W-1:0]  execWrData,
    output logic [`CPU_DATA_W-1:0]  execRdData,
    output logic                    execRdValid,
    output logic                    memWait,
    output busPkg::ownerT           owner
);

    logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];
    logic                   execGnt;
    logic                   fetchGnt;
    logic                   ramWe;
    logic [`CPU_ADDR_W-1:0] ramAddr;
    logic [`CPU_DATA_W-1:0] ramWrData;
    logic [`CPU_DATA_W-1:0] rdData;
    busPkg::ownerT          rdOwner;     // who gets rdData this cycle

    // fixed priority
    assign hostGnt  = hostReq && !run;
    assign execGnt  = execReq && !hostGnt;
    assign fetchGnt = fetchReq && !hostGnt && !execReq;

    // core lost arbitration, phaser holds
    assign memWait = (execReq && !execGnt) || (fetchReq && !fetchGnt);

    always_comb begin
        owner     = busPkg::ownNone;
        ramWe     = 1'b0;
        ramAddr   = fetchAddr;
        ramWrData = execWrData;
        if (hostGnt) begin
            owner     = busPkg::ownHost;
            ramWe     = 1'b1;            // host only ever writes
            ramAddr   = hostAddr;
            ramWrData = hostData;
        end else if (execGnt) begin
            owner   = busPkg::ownExec;
            ramWe   = execWe;
            ramAddr = execAddr;
        end else if (fetchGnt) begin
            owner = busPkg::ownFetch;
        end
    end

    always_ff @(posedge clk) begin
        if (ramWe) mem[ramAddr] <= ramWrData;
        rdData <= mem[ramAddr];
    end

    // writes return nothing
    always_ff @(posedge clk) begin
        if (!rstN) rdOwner <= busPkg::ownNone;
        else       rdOwner <= ramWe ? busPkg::ownNone : owner;
    end

    assign fetchRdData  = rdData;
    assign execRdData   = rdData;
    assign fetchRdValid = rdOwner == busPkg::ownFetch;
    assign execRdValid  = rdOwner == busPkg::ownExec;

    oneGrant: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({hostGnt, execGnt, fetchGnt}));

endmodule : sharedMem

// ==== src/cpuTop.sv ====
/* cpuTop, accumulator core with host loader port
   phaser, fetch and exec units around one shared memory */
`include "cpu_config.svh"

module cpuTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    run,
    input  logic [`CPU_ADDR_W-1:0]  hostAddr,
    input  logic [`CPU_DATA_W-1:0]  hostData,
    input  logic                    hostValid,
    output logic                    hostReady,
    output logic                    outValid,
    output logic [`CPU_DATA_W-1:0]  outData,
    output logic                    halted,
    output isaPkg::phaseT           phase,
    output busPkg::ownerT           owner
);

    logic [`CPU_SEQ_LEN-1:0] seq;
    logic                    memWait;
    logic                    branchTaken;
    logic [`CPU_ADDR_W-1:0]  branchTarget;
    logic                    fetchReq, fetchRdValid;
    logic [`CPU_ADDR_W-1:0]  fetchAddr;
    logic [`CPU_DATA_W-1:0]  fetchRdData, instr;
    logic                    execReq, execWe, execRdValid;
    logic [`CPU_ADDR_W-1:0]  execAddr;
    logic [`CPU_DATA_W-1:0]  execWrData, execRdData;

    phaser u_phaser (.clk, .rstN, .run, .stall(memWait), .halt(halted), .seq, .phase);

    fetchUnit u_fetchUnit (.clk, .rstN, .seq, .branchTaken, .branchTarget,
        .memReq(fetchReq), .memAddr(fetchAddr), .memRdData(fetchRdData),
        .memRdValid(fetchRdValid), .instr, .pc());     // pc only feeds memAddr

    execUnit u_execUnit (.clk, .rstN, .seq, .instr, .memReq(execReq), .memWe(execWe),
        .memAddr(execAddr), .memWrData(execWrData), .memRdData(execRdData),
        .memRdValid(execRdValid), .branchTaken, .branchTarget, .outValid, .outData,
        .halted);

    // hostReady is the host grant
    sharedMem u_sharedMem (.clk, .rstN, .run, .hostReq(hostValid), .hostAddr, .hostData,
        .hostGnt(hostReady), .fetchReq, .fetchAddr, .fetchRdData, .fetchRdValid,
        .execReq, .execWe, .execAddr, .execWrData, .execRdData, .execRdValid,
        .memWait, .owner);

endmodule : cpuTop

// ==== dv/cpuTb.sv ====
/* directed testbench for the accumulator core
   host loader, test tasks, typed compare tasks and summary */
`include "cpu_config.svh"

module cpuTb;
    timeunit 1ns;
    timeprecision 1ns;

    typedef logic [`CPU_DATA_W-1:0] dataT;
    typedef logic [`CPU_OPND_W-1:0] opndT;

    logic                   clk, rstN, run, hostValid, hostReady, outValid, halted;
    logic [`CPU_ADDR_W-1:0] hostAddr;
    dataT                   hostData, outData;
    isaPkg::phaseT          phase;
    busPkg::ownerT          owner;
    integer                 seed = 32'h8a102dfa;
    int                     errors = 0;
    int                     tests = 0;
    int                     cycle = 0;          // free-running cycle count for pulse spacing

    cpuTop i_cpuTop (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic checkData(input dataT got, input dataT exp, input string what);
        if (got !== exp) begin
            $display("** Error @%0t ns: %s got %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkPhase(input isaPkg::phaseT got, input isaPkg::phaseT exp,
                              input string what);
        if (got !== exp) begin
            $display("** Error @%0t ns: %s got %s, expected %s", $time, what, got.name(),
                     exp.name());
            errors++;
        end
    endtask

    task automatic checkOwner(input busPkg::ownerT got, input busPkg::ownerT exp,
                              input string what);
        if (got !== exp) begin
            $display("** Error @%0t ns: %s got %s, expected %s", $time, what, got.name(),
                     exp.name());
            errors++;
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error @%0t ns: %s got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("** Error @%0t ns: %s got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // opcode in the top 3 bits and operand below
    function automatic dataT enc(input isaPkg::opcodeT op, input opndT a);
        return {op, a};
    endfunction

    task automatic restart();
        @(posedge clk);
        run  <= 1'b0;
        rstN <= 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
    endtask

    // one host write that gives up after limit cycles without hostReady
    task automatic writeByte(input logic [`CPU_ADDR_W-1:0] a, input dataT d, input int limit,
                             output bit ok);
        ok = 1'b0;
        @(posedge clk);
        hostAddr  <= a;
        hostData  <= d;
        hostValid <= 1'b1;
        for (int i = 0; i < limit && !ok; i++) begin
            @(negedge clk);
            if (hostReady) begin
                ok = 1'b1;                      // transfer on the next edge
                checkOwner(owner, busPkg::ownHost, "owner during host write");
            end
        end
        @(posedge clk);
        hostValid <= 1'b0;
    endtask

    task automatic loadByte(input logic [`CPU_ADDR_W-1:0] a, input dataT d);
        bit ok;
        writeByte(a, d, 20, ok);
        if (!ok) begin
            $display("host write to %0h timed out waiting for hostReady", a);
            errors++;
        end
    endtask

    task automatic loadProgram(input dataT prog[$]);
        foreach (prog[i]) loadByte(i[`CPU_ADDR_W-1:0], prog[i]);   // program from 0
    endtask

    task automatic waitOut(output dataT val, output int at);
        bit ok;
        ok  = 1'b0;
        val = '0;
        at  = 0;
        for (int i = 0; i < 200 && !ok; i++) begin
            @(negedge clk);
            if (outValid) begin
                ok  = 1'b1;
                val = outData;
                at  = cycle;
            end
        end
        if (!ok) begin
            $display("timed out after 200 cycles waiting for outValid");
            errors++;
        end
    endtask

    // counts stray output pulses on the way to halt
    task automatic waitHalt(output int extra);
        extra = 0;
        for (int i = 0; i < 300 && !halted; i++) begin
            @(negedge clk);
            if (outValid) extra++;
        end
        if (!halted) begin
            $display("timed out after 300 cycles waiting for halted");
            errors++;
        end
    endtask

    task automatic startRun();
        @(posedge clk);
        run <= 1'b1;
    endtask

    task automatic report(input string name, input int e0);
        tests++;
        $display("test %s: %0d errors", name, errors - e0);
    endtask

    task automatic testIdle();
        int e0;
        e0 = errors;
        restart();
        repeat (3) begin
            @(negedge clk);
            checkFlag(outValid, 1'b0, "idle outValid");
            checkFlag(halted, 1'b0, "idle halted");
            checkPhase(phase, isaPkg::phDead, "idle phase");
            checkOwner(owner, busPkg::ownNone, "idle owner");    // no request after reset
        end
        loadByte(8'd31, 8'h00);                 // grant and owner checked inside
        report("reset and idle", e0);
    endtask

    task automatic testArith();
        dataT a, b, c, v1, v2, v3;
        dataT prog[$];
        int   t1, t2, t3, extra, e0;
        e0 = errors;
        a  = dataT'($random(seed));
        b  = dataT'($random(seed));
        c  = dataT'($random(seed));
        prog = {enc(isaPkg::LDA, 5'd20), enc(isaPkg::ADD, 5'd21), enc(isaPkg::OUT, 5'd0),
                enc(isaPkg::SUB, 5'd22), enc(isaPkg::OUT, 5'd0), enc(isaPkg::OUT, 5'd0),
                enc(isaPkg::HLT, 5'd0)};
        restart();
        loadProgram(prog);
        loadByte(8'd20, a);
        loadByte(8'd21, b);
        loadByte(8'd22, c);
        startRun();
        @(negedge clk);
        checkOwner(owner, busPkg::ownNone, "owner on the dead step");
        @(negedge clk);
        checkOwner(owner, busPkg::ownFetch, "owner on the first fetch");  // one cycle after run
        checkPhase(phase, isaPkg::phFetch, "phase on the first fetch");
        waitOut(v1, t1);
        waitOut(v2, t2);
        waitOut(v3, t3);
        checkData(v1, dataT'(a + b), "a+b");
        checkData(v2, dataT'(a + b - c), "a+b-c");
        checkData(v3, dataT'(a + b - c), "repeated out");
        checkCount(t2 - t1, 2 * `CPU_SEQ_LEN, "cycles across SUB");   // two instructions
        checkCount(t3 - t2, `CPU_SEQ_LEN, "cycles between back-to-back OUT");
        waitHalt(extra);
        checkCount(extra, 0, "outputs before halt");
        report("arithmetic", e0);
    endtask

    task automatic testStoreLoad();
        dataT a, v;
        dataT prog[$];
        int   t, extra, e0;
        e0 = errors;
        a  = dataT'($random(seed));
        prog = {enc(isaPkg::LDA, 5'd20), enc(isaPkg::STA, 5'd23), enc(isaPkg::LDA, 5'd24),
                enc(isaPkg::LDA, 5'd23), enc(isaPkg::OUT, 5'd0), enc(isaPkg::HLT, 5'd0)};
        restart();
        loadProgram(prog);
        loadByte(8'd20, a);
        loadByte(8'd23, ~a);                    // stale value the store must replace
        loadByte(8'd24, 8'h00);
        startRun();
        waitOut(v, t);
        checkData(v, a, "stored then reloaded");
        waitHalt(extra);
        checkCount(extra, 0, "outputs before halt");
        report("store and load", e0);
    endtask

    task automatic testBranch();
        dataT v;
        dataT prog[$];
        int   n, t, extra, e0;
        e0 = errors;
        n  = 2 + ($random(seed) & 7);
        prog = {enc(isaPkg::LDA, 5'd20), enc(isaPkg::SUB, 5'd21), enc(isaPkg::OUT, 5'd0),
                enc(isaPkg::JZ, 5'd5), enc(isaPkg::JMP, 5'd1), enc(isaPkg::HLT, 5'd0)};
        restart();
        loadProgram(prog);
        loadByte(8'd20, dataT'(n));
        loadByte(8'd21, 8'd1);
        startRun();
        for (int k = n - 1; k >= 0; k--) begin
            waitOut(v, t);
            checkData(v, dataT'(k), "countdown value");
        end
        waitHalt(extra);
        checkCount(extra, 0, "outputs after zero");
        report("branches", e0);
    endtask

    task automatic testHalt();
        dataT          a;
        dataT          v;
        dataT          prog[$];
        isaPkg::phaseT held;
        int            t, extra, e0;
        bit            ok;
        e0 = errors;
        a  = dataT'($random(seed));
        prog = {enc(isaPkg::LDA, 5'd20), enc(isaPkg::OUT, 5'd0), enc(isaPkg::HLT, 5'd0)};
        restart();
        loadProgram(prog);
        loadByte(8'd20, a);
        startRun();
        waitOut(v, t);
        checkData(v, a, "output before halt");
        waitHalt(extra);
        checkCount(extra, 0, "outputs between OUT and halt");
        checkFlag(halted, 1'b1, "halted after HLT");
        held  = phase;
        extra = 0;
        repeat (50) begin
            @(negedge clk);
            checkPhase(phase, held, "phase while halted");
            if (outValid) extra++;
        end
        checkCount(extra, 0, "outValid while halted");
        writeByte(8'd25, 8'h5a, 20, ok);        // run still high
        if (ok) begin
            $display("host write was accepted while run was high");
            errors++;
        end else begin
            $display("host write held off while run is high, expected back-pressure");
        end
        @(posedge clk);
        run <= 1'b0;
        loadByte(8'd25, 8'h5a);
        report("halt and back-pressure", e0);
    endtask

    initial begin
        rstN      = 1'b0;
        run       = 1'b0;
        hostValid = 1'b0;
        hostAddr  = '0;
        hostData  = '0;
        testIdle();
        testArith();
        testStoreLoad();
        testBranch();
        testHalt();
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : cpuTb

// ==== files.f ====
+incdir+src
src/isaPkg.sv
src/busPkg.sv
src/phaser.sv
src/fetchUnit.sv
src/execUnit.sv
src/sharedMem.sv
src/cpuTop.sv
dv/cpuTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# compile with verilator and run, status follows the testbench verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module cpuTb \
    -o cpuTbSim &&
./obj_dir/cpuTbSim | tee /dev/stderr | grep -qx "sim passed" ||
{ echo "simulation did not pass"; exit 1; }
